// ==== hdl/cgra_pkg.sv ====
/*
 * CGRA shared definitions: data and constant widths, array geometry,
 * bitstream layout, opcode/source/direction encodings and the PE
 * configuration word
 */
package cgra_pkg;

    // Datapath
    localparam int DATA_WIDTH  = 16;
    localparam int CONST_WIDTH = 8;

    // Array geometry
    localparam int NUM_ROWS     = 2;
    localparam int NUM_COLS     = 2;
    localparam int NUM_PES      = NUM_ROWS * NUM_COLS;
    localparam int PE_IDX_WIDTH = 2;

    // Bitstream layout: {write, pe index, configuration word}
    localparam int CFG_WIDTH       = 16;
    localparam int BS_IDX_LSB      = CFG_WIDTH;
    localparam int BS_WRITE_BIT    = BS_IDX_LSB + PE_IDX_WIDTH;
    localparam int BITSTREAM_WIDTH = BS_WRITE_BIT + 1;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_PASS = 3'd5
    } pe_op_e;

    // Code 3 is unused and reads as zero
    typedef enum logic [1:0] {
        SRC_NORTH = 2'd0,
        SRC_WEST  = 2'd1,
        SRC_CONST = 2'd2
    } pe_src_e;

    typedef enum logic {
        DIR_SOUTH = 1'b0,
        DIR_EAST  = 1'b1
    } pe_dir_e;

    // Top bit down: op, src_a, src_b, dir, constant
    typedef struct packed {
        pe_op_e                 op;
        pe_src_e                src_a;
        pe_src_e                src_b;
        pe_dir_e                dir;
        logic [CONST_WIDTH-1:0] const_val;
    } pe_cfg_t;

endpackage

// ==== hdl/cgra_config_decoder.sv ====
/*
 * CGRA configuration decoder: per-PE write strobes from the bitstream
 * write, sticky PE enables, and the run vector qualified by execute
 */
`timescale 1ns/1ps

module cgra_config_decoder (
    input  logic                              clk,
    input  logic                              rst_n_bs,
    input  logic                              bitstream_enable_i,
    input  logic                              cfg_write_i,
    input  logic [cgra_pkg::PE_IDX_WIDTH-1:0] pe_idx_i,
    input  logic                              execute_i,
    output logic [cgra_pkg::NUM_PES-1:0]      cfg_we_o,
    output logic [cgra_pkg::NUM_PES-1:0]      pe_run_o
);

    import cgra_pkg::*;

    logic [NUM_PES-1:0] pe_en_q;
    logic               write_req;

    assign write_req = bitstream_enable_i && cfg_write_i;

    // One strobe per PE, index match
    always_comb begin
        for (int i = 0; i < NUM_PES; i++) begin
            cfg_we_o[i] = write_req && (pe_idx_i == PE_IDX_WIDTH'(i));
        end
    end

    // Enable sticks once the PE has been written
    always_ff @(posedge clk or negedge rst_n_bs) begin
        if (!rst_n_bs) begin
            pe_en_q <= '0;
        end else begin
            pe_en_q <= pe_en_q | cfg_we_o;
        end
    end

    assign pe_run_o = pe_en_q & {NUM_PES{execute_i}};

endmodule

// ==== hdl/cgra_alu.sv ====
/*
 * CGRA PE operation unit, purely combinational, opcode selected,
 * all results modulo 2^16
 */
`timescale 1ns/1ps

module cgra_alu (
    input  cgra_pkg::pe_op_e                op_i,
    input  logic [cgra_pkg::DATA_WIDTH-1:0] a_i,
    input  logic [cgra_pkg::DATA_WIDTH-1:0] b_i,
    output logic [cgra_pkg::DATA_WIDTH-1:0] result_o
);

    import cgra_pkg::*;

    always_comb begin
        case (op_i)
            OP_ADD: begin
                result_o = a_i + b_i;
            end
            OP_SUB: begin
                result_o = a_i - b_i;
            end
            OP_AND: begin
                result_o = a_i & b_i;
            end
            OP_OR: begin
                result_o = a_i | b_i;
            end
            OP_XOR: begin
                result_o = a_i ^ b_i;
            end
            OP_PASS: begin
                result_o = a_i;
            end
            // Unused codes
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== hdl/cgra_pe.sv ====
/*
 * CGRA processing element: configuration register, operand selection,
 * firing rule over valid/ready links and a one-entry output stage
 * presented south or east
 */
`timescale 1ns/1ps

module cgra_pe (
    input  logic                            clk,
    input  logic                            rst_n_bs,
    input  logic                            cfg_we_i,
    input  cgra_pkg::pe_cfg_t               cfg_i,
    input  logic                            run_i,

    // North input
    input  logic [cgra_pkg::DATA_WIDTH-1:0] north_din_i,
    input  logic                            north_din_v_i,
    output logic                            north_din_r_o,

    // West input
    input  logic [cgra_pkg::DATA_WIDTH-1:0] west_din_i,
    input  logic                            west_din_v_i,
    output logic                            west_din_r_o,

    // South output
    output logic [cgra_pkg::DATA_WIDTH-1:0] south_dout_o,
    output logic                            south_dout_v_o,
    input  logic                            south_dout_r_i,

    // East output
    output logic [cgra_pkg::DATA_WIDTH-1:0] east_dout_o,
    output logic                            east_dout_v_o,
    input  logic                            east_dout_r_i
);

    import cgra_pkg::*;

    pe_cfg_t               cfg_q;
    logic [DATA_WIDTH-1:0] const_ext;
    logic [DATA_WIDTH-1:0] opa;
    logic [DATA_WIDTH-1:0] opb;
    logic [DATA_WIDTH-1:0] alu_res;
    logic [DATA_WIDTH-1:0] out_q;
    logic                  out_v_q;
    logic                  need_north;
    logic                  need_west;
    logic                  inputs_ok;
    logic                  drain;
    logic                  fire;

    function automatic logic [DATA_WIDTH-1:0] select_operand(
        input pe_src_e               src,
        input logic [DATA_WIDTH-1:0] north,
        input logic [DATA_WIDTH-1:0] west,
        input logic [DATA_WIDTH-1:0] cnst
    );
        logic [DATA_WIDTH-1:0] val;
        case (src)
            SRC_NORTH: val = north;
            SRC_WEST:  val = west;
            SRC_CONST: val = cnst;
            default:   val = '0;
        endcase
        return val;
    endfunction

    always_ff @(posedge clk or negedge rst_n_bs) begin
        if (!rst_n_bs) begin
            cfg_q <= '0;
        end else if (cfg_we_i) begin
            cfg_q <= cfg_i;
        end
    end

    assign const_ext = DATA_WIDTH'(cfg_q.const_val);
    assign opa       = select_operand(cfg_q.src_a, north_din_i, west_din_i, const_ext);
    assign opb       = select_operand(cfg_q.src_b, north_din_i, west_din_i, const_ext);

    cgra_alu alu_i (
        .op_i     ( cfg_q.op ),
        .a_i      ( opa      ),
        .b_i      ( opb      ),
        .result_o ( alu_res  )
    );

    // A port named by both sources is consumed once
    assign need_north = (cfg_q.src_a == SRC_NORTH) || (cfg_q.src_b == SRC_NORTH);
    assign need_west  = (cfg_q.src_a == SRC_WEST) || (cfg_q.src_b == SRC_WEST);
    assign inputs_ok  = (!need_north || north_din_v_i) && (!need_west || west_din_v_i);

    // Only the selected direction's ready empties the stage
    assign drain = out_v_q && ((cfg_q.dir == DIR_EAST) ? east_dout_r_i : south_dout_r_i);
    assign fire  = run_i && inputs_ok && (!out_v_q || drain);

    assign north_din_r_o = fire && need_north;
    assign west_din_r_o  = fire && need_west;

    always_ff @(posedge clk or negedge rst_n_bs) begin
        if (!rst_n_bs) begin
            out_v_q <= 1'b0;
        end else if (fire) begin
            out_v_q <= 1'b1;
        end else if (drain) begin
            out_v_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_q <= alu_res;
        end
    end

    assign south_dout_o   = out_q;
    assign east_dout_o    = out_q;
    assign south_dout_v_o = out_v_q && (cfg_q.dir == DIR_SOUTH);
    assign east_dout_v_o  = out_v_q && (cfg_q.dir == DIR_EAST);

endmodule

// ==== hdl/cgra_top.sv ====
/*
 * CGRA top level: 2x2 grid of PEs with elastic south and east links,
 * north input lanes on row 0, south output lanes on row 1
 */
`timescale 1ns/1ps

module cgra_top (
    input  logic                                                 clk,
    input  logic                                                 rst_n_bs,

    // Input lanes, lane 0 in the low bits
    input  logic [cgra_pkg::NUM_COLS*cgra_pkg::DATA_WIDTH-1:0]   data_in_i,
    input  logic [cgra_pkg::NUM_COLS-1:0]                        data_in_valid_i,
    output logic [cgra_pkg::NUM_COLS-1:0]                        data_in_ready_o,

    // Output lanes
    output logic [cgra_pkg::NUM_COLS*cgra_pkg::DATA_WIDTH-1:0]   data_out_o,
    output logic [cgra_pkg::NUM_COLS-1:0]                        data_out_valid_o,
    input  logic [cgra_pkg::NUM_COLS-1:0]                        data_out_ready_i,

    // Configuration
    input  logic [cgra_pkg::BITSTREAM_WIDTH-1:0]                 config_bitstream_i,
    input  logic                                                 bitstream_enable_i,
    input  logic                                                 execute_i
);

    import cgra_pkg::*;

    pe_cfg_t                cfg_word;
    logic [NUM_PES-1:0]     cfg_we;
    logic [NUM_PES-1:0]     pe_run;

    // Per-PE port wires, indexed row * NUM_COLS + col
    logic [NUM_PES-1:0][DATA_WIDTH-1:0] north_d;
    logic [NUM_PES-1:0][DATA_WIDTH-1:0] west_d;
    logic [NUM_PES-1:0][DATA_WIDTH-1:0] south_d;
    logic [NUM_PES-1:0][DATA_WIDTH-1:0] east_d;
    logic [NUM_PES-1:0]                 north_v;
    logic [NUM_PES-1:0]                 north_r;
    logic [NUM_PES-1:0]                 west_v;
    logic [NUM_PES-1:0]                 west_r;
    logic [NUM_PES-1:0]                 south_v;
    logic [NUM_PES-1:0]                 south_r;
    logic [NUM_PES-1:0]                 east_v;
    logic [NUM_PES-1:0]                 east_r;

    assign cfg_word = pe_cfg_t'(config_bitstream_i[CFG_WIDTH-1:0]);

    cgra_config_decoder decoder_i (
        .clk                ( clk                                              ),
        .rst_n_bs           ( rst_n_bs                                         ),
        .bitstream_enable_i ( bitstream_enable_i                               ),
        .cfg_write_i        ( config_bitstream_i[BS_WRITE_BIT]                 ),
        .pe_idx_i           ( config_bitstream_i[BS_IDX_LSB +: PE_IDX_WIDTH]   ),
        .execute_i          ( execute_i                                        ),
        .cfg_we_o           ( cfg_we                                           ),
        .pe_run_o           ( pe_run                                           )
    );

    for (genvar r = 0; r < NUM_ROWS; r++) begin : gen_row
        for (genvar c = 0; c < NUM_COLS; c++) begin : gen_col
            localparam int IDX = r * NUM_COLS + c;

            // North side: input lane or the PE above
            if (r == 0) begin : gen_lane_in
                assign north_d[IDX]       = data_in_i[c*DATA_WIDTH +: DATA_WIDTH];
                assign north_v[IDX]       = data_in_valid_i[c];
                assign data_in_ready_o[c] = north_r[IDX];
            end else begin : gen_link_ns
                assign north_d[IDX]          = south_d[IDX-NUM_COLS];
                assign north_v[IDX]          = south_v[IDX-NUM_COLS];
                assign south_r[IDX-NUM_COLS] = north_r[IDX];
            end

            // West side: tied invalid on the left edge
            if (c == 0) begin : gen_west_tie
                assign west_d[IDX] = '0;
                assign west_v[IDX] = 1'b0;
            end else begin : gen_link_we
                assign west_d[IDX]   = east_d[IDX-1];
                assign west_v[IDX]   = east_v[IDX-1];
                assign east_r[IDX-1] = west_r[IDX];
            end

            // Right edge never accepts east output
            if (c == NUM_COLS - 1) begin : gen_east_tie
                assign east_r[IDX] = 1'b0;
            end

            if (r == NUM_ROWS - 1) begin : gen_lane_out
                assign data_out_o[c*DATA_WIDTH +: DATA_WIDTH] = south_d[IDX];
                assign data_out_valid_o[c]                    = south_v[IDX];
                assign south_r[IDX]                           = data_out_ready_i[c];
            end

            cgra_pe pe_i (
                .clk            ( clk          ),
                .rst_n_bs       ( rst_n_bs     ),
                .cfg_we_i       ( cfg_we[IDX]  ),
                .cfg_i          ( cfg_word     ),
                .run_i          ( pe_run[IDX]  ),
                .north_din_i    ( north_d[IDX] ),
                .north_din_v_i  ( north_v[IDX] ),
                .north_din_r_o  ( north_r[IDX] ),
                .west_din_i     ( west_d[IDX]  ),
                .west_din_v_i   ( west_v[IDX]  ),
                .west_din_r_o   ( west_r[IDX]  ),
                .south_dout_o   ( south_d[IDX] ),
                .south_dout_v_o ( south_v[IDX] ),
                .south_dout_r_i ( south_r[IDX] ),
                .east_dout_o    ( east_d[IDX]  ),
                .east_dout_v_o  ( east_v[IDX]  ),
                .east_dout_r_i  ( east_r[IDX]  )
            );
        end
    end

endmodule

// ==== bench/cgra_tb.sv ====
/*
 * Testbench for the 2x2 CGRA: a table of configurations applied in a loop,
 * random lane words, in-order checking per output lane against a model
 */
`timescale 1ns/1ps

module cgra_tb;

    import cgra_pkg::*;

    localparam int NUM_TESTS = 9;
    localparam int MAX_WORDS = 32;
    localparam int CLK_HALF  = 20;

    logic                           clk;
    logic                           rst_n_bs;
    logic [NUM_COLS*DATA_WIDTH-1:0] in_data;
    logic [NUM_COLS-1:0]            in_valid;
    logic [NUM_COLS-1:0]            in_ready;
    logic [NUM_COLS*DATA_WIDTH-1:0] out_data;
    logic [NUM_COLS-1:0]            out_valid;
    logic [NUM_COLS-1:0]            out_ready;
    logic [BITSTREAM_WIDTH-1:0]     bitstream;
    logic                           bs_enable;
    logic                           execute;

    // Stimulus table, one row per test
    string      tbl_name  [NUM_TESTS];
    pe_cfg_t    tbl_cfg   [NUM_TESTS][NUM_PES];
    logic [3:0] tbl_mask  [NUM_TESTS];
    int         tbl_count [NUM_TESTS];
    int         tbl_bp    [NUM_TESTS];
    int         tbl_xs    [NUM_TESTS];
    int         tbl_xl    [NUM_TESTS];

    // Model state
    pe_cfg_t               cur_cfg [NUM_PES];
    logic [DATA_WIDTH-1:0] in_w    [NUM_COLS][MAX_WORDS];
    logic [DATA_WIDTH-1:0] exp_w   [NUM_COLS][MAX_WORDS];
    int                    exp_n   [NUM_COLS];
    int                    errors;
    int                    tests_failed;

    cgra_top dut_i (
        .clk                ( clk        ),
        .rst_n_bs           ( rst_n_bs   ),
        .data_in_i          ( in_data    ),
        .data_in_valid_i    ( in_valid   ),
        .data_in_ready_o    ( in_ready   ),
        .data_out_o         ( out_data   ),
        .data_out_valid_o   ( out_valid  ),
        .data_out_ready_i   ( out_ready  ),
        .config_bitstream_i ( bitstream  ),
        .bitstream_enable_i ( bs_enable  ),
        .execute_i          ( execute    )
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    function automatic logic [DATA_WIDTH-1:0] operand_value(input pe_src_e src, input pe_cfg_t c,
            input logic [DATA_WIDTH-1:0] n, input logic [DATA_WIDTH-1:0] w);
        case (src)
            SRC_NORTH: return n;
            SRC_WEST:  return w;
            SRC_CONST: return DATA_WIDTH'(c.const_val);
            default:   return '0;
        endcase
    endfunction

    function automatic logic [DATA_WIDTH-1:0] expected_result(input pe_cfg_t c,
            input logic [DATA_WIDTH-1:0] n, input logic [DATA_WIDTH-1:0] w);
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        a = operand_value(c.src_a, c, n, w);
        b = operand_value(c.src_b, c, n, w);
        case (c.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_PASS: return a;
            default: return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    // Row-0 and row-1 PEs take north and the constant; ops and constants listed PE3 first
    task automatic set_row(input int t, input string name, input logic [3:0][2:0] ops,
                           input logic [3:0][7:0] ks, input logic [3:0] dir,
                           input logic [3:0] mask, input int cnt, input int bp,
                           input int xs, input int xl);
        for (int p = 0; p < NUM_PES; p++) begin
            tbl_cfg[t][p].op        = pe_op_e'(ops[p]);
            tbl_cfg[t][p].src_a     = SRC_NORTH;
            tbl_cfg[t][p].src_b     = SRC_CONST;
            tbl_cfg[t][p].dir       = dir[p] ? DIR_EAST : DIR_SOUTH;
            tbl_cfg[t][p].const_val = ks[p];
        end
        tbl_name[t]  = name;
        tbl_mask[t]  = mask;
        tbl_count[t] = cnt;
        tbl_bp[t]    = bp;
        tbl_xs[t]    = xs;
        tbl_xl[t]    = xl;
    endtask

    task automatic build_table();
        set_row(0, "add_sub", {OP_PASS, OP_PASS, OP_SUB, OP_ADD}, 32'h0000_5a3c,
                4'b0000, 4'b1111, 8, 0, 0, 0);
        set_row(1, "and_or", {OP_ADD, OP_XOR, OP_OR, OP_AND}, 32'h1177_81f0,
                4'b0000, 4'b1111, 8, 0, 0, 0);
        set_row(2, "xor_pass", {OP_AND, OP_SUB, OP_PASS, OP_XOR}, 32'hcc09_00a5,
                4'b0000, 4'b1111, 8, 0, 0, 0);
        set_row(3, "or_add", {OP_XOR, OP_ADD, OP_ADD, OP_OR}, 32'h3e01_ff42,
                4'b0000, 4'b1111, 8, 0, 0, 0);
        set_row(4, "pass_xor", {OP_SUB, OP_OR, OP_XOR, OP_PASS}, 32'h8018_6b00,
                4'b0000, 4'b1111, 8, 0, 0, 0);
        set_row(5, "sub_and_backpressure", {OP_PASS, OP_PASS, OP_AND, OP_SUB}, 32'h0000_0f07,
                4'b0000, 4'b1111, 16, 50, 0, 0);
        set_row(6, "execute_gap", {OP_PASS, OP_PASS, OP_AND, OP_SUB}, 32'h0000_0f07,
                4'b0000, 4'b0000, 12, 0, 6, 15);
        set_row(7, "reconfig_pe2", {OP_PASS, OP_XOR, OP_PASS, OP_PASS}, 32'h005c_0000,
                4'b0000, 4'b0100, 8, 0, 0, 0);
        set_row(8, "east_route", {OP_PASS, OP_PASS, OP_SUB, OP_ADD}, 32'h0000_0010,
                4'b0001, 4'b1011, 8, 0, 0, 0);
        // PE1 subtracts lane 1 from PE0's eastward result
        tbl_cfg[8][1].src_a = SRC_WEST;
        tbl_cfg[8][1].src_b = SRC_NORTH;
    endtask

    task automatic write_config(input int t);
        for (int p = 0; p < NUM_PES; p++) begin
            if (tbl_mask[t][p]) begin
                cur_cfg[p] = tbl_cfg[t][p];
                @(posedge clk);
                bs_enable <= 1'b1;
                bitstream <= {1'b1, PE_IDX_WIDTH'(p), tbl_cfg[t][p]};
            end
        end
        @(posedge clk);
        bs_enable <= 1'b0;
        bitstream <= '0;
    endtask

    // West values only matter for the east-routed row
    task automatic build_expected(input int t);
        logic [DATA_WIDTH-1:0] r0;
        logic [DATA_WIDTH-1:0] r1;
        logic [DATA_WIDTH-1:0] r2;
        logic [DATA_WIDTH-1:0] r3;
        exp_n[0] = 0;
        exp_n[1] = 0;
        for (int i = 0; i < tbl_count[t]; i++) begin
            in_w[0][i] = DATA_WIDTH'($urandom());
            in_w[1][i] = DATA_WIDTH'($urandom());
            r0 = expected_result(cur_cfg[0], in_w[0][i], '0);
            r1 = expected_result(cur_cfg[1], in_w[1][i], r0);
            r2 = expected_result(cur_cfg[2], r0, '0);
            r3 = expected_result(cur_cfg[3], r1, r2);
            if (cur_cfg[0].dir == DIR_SOUTH && cur_cfg[2].dir == DIR_SOUTH) begin
                exp_w[0][exp_n[0]] = r2;
                exp_n[0]++;
            end
            if (cur_cfg[1].dir == DIR_SOUTH && cur_cfg[3].dir == DIR_SOUTH) begin
                exp_w[1][exp_n[1]] = r3;
                exp_n[1]++;
            end
        end
    endtask

    task automatic check_reset_idle();
        int err_start;
        err_start = errors;
        @(posedge clk);
        execute   <= 1'b1;
        in_valid  <= '1;
        in_data   <= {DATA_WIDTH'('h1234), DATA_WIDTH'('h5678)};
        out_ready <= '1;
        repeat (6) begin
            @(negedge clk);
            check_value("data_out_valid_o", 32'(out_valid), 0);
            check_value("data_in_ready_o", 32'(in_ready), 0);
        end
        @(posedge clk);
        in_valid <= '0;
        report_test("reset_idle", err_start);
    endtask

    task automatic run_test(input int t);
        int                    sent       [NUM_COLS];
        int                    rd         [NUM_COLS];
        int                    stall_outs [NUM_COLS];
        int                    cyc;
        int                    err_start;
        bit                    saw_drop;
        logic [DATA_WIDTH-1:0] got;
        err_start = errors;
        write_config(t);
        build_expected(t);
        cyc      = 0;
        saw_drop = 1'b0;
        for (int c = 0; c < NUM_COLS; c++) begin
            sent[c]       = 0;
            rd[c]         = 0;
            stall_outs[c] = 0;
        end
        while (sent[0] < tbl_count[t] || sent[1] < tbl_count[t] ||
               rd[0] < exp_n[0] || rd[1] < exp_n[1]) begin
            @(posedge clk);
            for (int c = 0; c < NUM_COLS; c++) begin
                in_valid[c] <= (sent[c] < tbl_count[t]);
                in_data[c*DATA_WIDTH +: DATA_WIDTH] <= in_w[c][sent[c]];
                out_ready[c] <= ($urandom_range(99, 0) >= tbl_bp[t]);
            end
            execute <= !(cyc >= tbl_xs[t] && cyc < tbl_xs[t] + tbl_xl[t]);
            // Handshakes are settled mid-cycle and complete on the next edge
            @(negedge clk);
            for (int c = 0; c < NUM_COLS; c++) begin
                if (!execute) begin
                    check_value($sformatf("data_in_ready_o[%0d]", c), 32'(in_ready[c]), 0);
                    if (out_valid[c] && out_ready[c]) begin
                        stall_outs[c]++;
                    end
                end
                if (in_valid[c] && !in_ready[c]) begin
                    saw_drop = 1'b1;
                end
                if (in_valid[c] && in_ready[c]) begin
                    sent[c]++;
                end
                if (out_valid[c] && out_ready[c]) begin
                    got = out_data[c*DATA_WIDTH +: DATA_WIDTH];
                    if (rd[c] < exp_n[c]) begin
                        check_value($sformatf("data_out_o[%0d] word %0d", c, rd[c]),
                                    32'(got), 32'(exp_w[c][rd[c]]));
                        rd[c]++;
                    end else begin
                        errors++;
                        $display("Lane %0d delivered a word that was never expected", c);
                    end
                end
            end
            cyc++;
        end
        @(posedge clk);
        in_valid  <= '0;
        execute   <= 1'b1;
        out_ready <= '1;
        repeat (4) begin
            @(negedge clk);
            check_value("data_out_valid_o", 32'(out_valid), 0);
        end
        // Only the row-1 stage can drain while execution is held off
        for (int c = 0; c < NUM_COLS; c++) begin
            if (tbl_xl[t] > 0) begin
                check_value($sformatf("lane %0d outputs while halted", c),
                            32'(stall_outs[c] <= 1), 1);
            end
        end
        if (tbl_bp[t] > 0) begin
            check_value("data_in_ready_o low under back-pressure", 32'(saw_drop), 1);
        end
        report_test(tbl_name[t], err_start);
    endtask

    initial begin : watchdog
        int limit;
        @(posedge clk);
        limit = 200;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit += tbl_count[t] * 20;
        end
        repeat (limit) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clock cycles", limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h98ea2a35));
        errors       = 0;
        tests_failed = 0;
        rst_n_bs  <= 1'b0;
        in_data   <= '0;
        in_valid  <= '0;
        out_ready <= '0;
        bitstream <= '0;
        bs_enable <= 1'b0;
        execute   <= 1'b0;
        for (int p = 0; p < NUM_PES; p++) begin
            cur_cfg[p] = '0;
        end
        build_table();
        repeat (4) @(posedge clk);
        rst_n_bs <= 1'b1;
        check_reset_idle();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests run %0d, tests failed %0d, errors %0d",
                 NUM_TESTS + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hdl/cgra_pkg.sv
hdl/cgra_config_decoder.sv
hdl/cgra_alu.sv
hdl/cgra_pe.sv
hdl/cgra_top.sv
bench/cgra_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the CGRA testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing -j 0 -f compile.f --top-module cgra_tb -o cgra_sim \
    > build.log 2>&1 \
    && ./obj_dir/cgra_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
